//--- design/atom_bus_if.sv
// ============================================================
// Decoded bus access
// One qualified CPU access, as seen by the PIA and the
// response block
// ============================================================
`timescale 1ns/1ns
`default_nettype none

interface atom_bus_if;

   // Single-cycle strobe, high on the enable cycle that serves a request
   logic                              access;
   // Request attributes, valid while the request is held
   logic                              we;
   logic [atom_pkg::ADDR_W-1:0]       adr;
   logic [atom_pkg::DATA_W-1:0]       dat_w;
   // Decode results
   atom_pkg::region_e                 region;
   atom_pkg::pia_reg_e                pia_reg;

   // Decoder side
   modport source (output access, output we, output adr, output dat_w,
                   output region, output pia_reg);

   // PIA and response side
   modport sink (input access, input we, input adr, input dat_w,
                 input region, input pia_reg);

endinterface

`default_nettype wire

//--- design/atom_io_top.sv
// ============================================================
// Atom I/O and memory decode slice
// Wishbone slave in front of the SRAM, the 8255 PIA and the
// cassette logic, paced by the CPU clock enable
// ============================================================
`timescale 1ns/1ns
`default_nettype none

module atom_io_top
   (
   input  wire logic                          clk25,
   input  wire logic                          reset,
   input  wire logic [1:0]                    turbo,
   // Wishbone classic slave
   input  wire logic                          wb_cyc,
   input  wire logic                          wb_stb,
   input  wire logic                          wb_we,
   input  wire logic [atom_pkg::ADDR_W-1:0]   wb_adr,
   input  wire logic [atom_pkg::DATA_W-1:0]   wb_dat_w,
   output logic [atom_pkg::DATA_W-1:0]        wb_dat_r,
   output logic                               wb_ack,
   // External SRAM
   output logic                               ram_cs_b,
   output logic                               ram_oe_b,
   output logic                               ram_we_b,
   output logic [atom_pkg::RAM_ADDR_W-1:0]    ram_adr,
   input  wire logic [atom_pkg::DATA_W-1:0]   ram_dat_in,
   output logic [atom_pkg::DATA_W-1:0]        ram_dat_out,
   // Keyboard scanner results
   input  wire logic                          shift_n,
   input  wire logic                          ctrl_n,
   input  wire logic                          rept_n,
   input  wire logic [5:0]                    keyout,
   // Video field sync
   input  wire logic                          fs_n,
   // Cassette and sound
   input  wire logic                          cas_in,
   output logic                               cas_out,
   output logic                               sound,
   // Keyboard row in the low nibble, video mode in the high
   output logic [atom_pkg::DATA_W-1:0]        pia_pa
   );

   logic                        cpu_clken;
   logic [atom_pkg::DATA_W-1:0] pia_dout;
   logic [3:0]                  pia_pc_out;
   logic                        cas_tone;

   atom_bus_if bus ();

   // ============================================================
   // Timing and decode
   // ============================================================

   clock_enable_gen u_clock_enable_gen (
      .clk25     (clk25),
      .reset     (reset),
      .turbo     (atom_pkg::speed_e'(turbo)),
      .cpu_clken (cpu_clken)
   );

   // Ack still high blocks a second access on the same request
   bus_decode u_bus_decode (
      .clk25       (clk25),
      .reset       (reset),
      .cpu_clken   (cpu_clken),
      .wb_cyc      (wb_cyc),
      .wb_stb      (wb_stb),
      .wb_we       (wb_we),
      .wb_adr      (wb_adr),
      .wb_dat_w    (wb_dat_w),
      .ack_pending (wb_ack),
      .bus         (bus.source)
   );

   // ============================================================
   // Peripherals
   // ============================================================

   pia_8255 u_pia_8255 (
      .clk25      (clk25),
      .reset      (reset),
      .bus        (bus.sink),
      .shift_n    (shift_n),
      .ctrl_n     (ctrl_n),
      .keyout     (keyout),
      .fs_n       (fs_n),
      .rept_n     (rept_n),
      .cas_in     (cas_in),
      .cas_tone   (cas_tone),
      .pia_pa     (pia_pa),
      .pia_pc_out (pia_pc_out),
      .pia_dout   (pia_dout)
   );

   cassette_tone u_cassette_tone (
      .clk25      (clk25),
      .reset      (reset),
      .cpu_clken  (cpu_clken),
      .pia_pc_out (pia_pc_out),
      .cas_tone   (cas_tone),
      .cas_out    (cas_out),
      .sound      (sound)
   );

   // Response and SRAM
   bus_response u_bus_response (
      .clk25       (clk25),
      .reset       (reset),
      .bus         (bus.sink),
      .wb_stb      (wb_stb),
      .pia_dout    (pia_dout),
      .ram_dat_in  (ram_dat_in),
      .wb_ack      (wb_ack),
      .wb_dat_r    (wb_dat_r),
      .ram_cs_b    (ram_cs_b),
      .ram_oe_b    (ram_oe_b),
      .ram_we_b    (ram_we_b),
      .ram_adr     (ram_adr),
      .ram_dat_out (ram_dat_out)
   );

endmodule

`default_nettype wire

//--- design/atom_pkg.sv
// ============================================================
// Atom I/O slice shared definitions
// Bus widths, divider constants and the enums for regions,
// PIA registers and CPU speed settings
// ============================================================
`default_nettype none

package atom_pkg;

   // Bus widths
   localparam int ADDR_W     = 16;
   localparam int DATA_W     = 8;
   localparam int RAM_ADDR_W = 18;

   // CPU enable frame of clk25 cycles and its counter width
   localparam int CLKDIV_PERIOD = 25;
   localparam int CLKDIV_W      = $clog2(CLKDIV_PERIOD);
   // Faster speeds only place enables in the first 16 counts of a frame
   localparam int CLKDIV_WINDOW = 16;

   // Cassette tone, 208 enables per half-period (16 * 13)
   localparam int CAS_DIV_COUNT = 208;
   localparam int CAS_DIV_W     = $clog2(CAS_DIV_COUNT);

   // Unused space reads as the high address byte through pull-downs
   localparam logic [DATA_W-1:0] OPEN_BUS_MASK = 8'hF1;

   // Decoded address regions
   typedef enum logic [2:0] {
      region_ram,
      region_rom,
      region_pia,
      region_pl8,
      region_open_bus
   } region_e;

   // 8255 register select, straight from address bits 1:0
   typedef enum logic [1:0] {
      pia_port_a  = 2'b00,
      pia_port_b  = 2'b01,
      pia_port_c  = 2'b10,
      pia_control = 2'b11
   } pia_reg_e;

   // Turbo settings
   typedef enum logic [1:0] {
      speed_1mhz = 2'b00,
      speed_2mhz = 2'b01,
      speed_4mhz = 2'b10,
      speed_8mhz = 2'b11
   } speed_e;

endpackage

`default_nettype wire

//--- design/bus_decode.sv
// ============================================================
// Bus address decoder
// Maps the CPU address onto a region and PIA register and
// qualifies a held Wishbone request with the CPU enable
// ============================================================
`timescale 1ns/1ns
`default_nettype none

module bus_decode
   (
   input  wire logic                        clk25,
   input  wire logic                        reset,
   input  wire logic                        cpu_clken,
   input  wire logic                        wb_cyc,
   input  wire logic                        wb_stb,
   input  wire logic                        wb_we,
   input  wire logic [atom_pkg::ADDR_W-1:0] wb_adr,
   input  wire logic [atom_pkg::DATA_W-1:0] wb_dat_w,
   input  wire logic                        ack_pending,
   atom_bus_if.source                       bus
   );

   // Request already served, held until the master drops stb
   logic served;

   // Region map, ROM checked first as it overlaps the top bit
   always_comb
   begin
      if (wb_adr[15:14] == 2'b11)
         bus.region = atom_pkg::region_rom;
      else if (!wb_adr[15])
         bus.region = atom_pkg::region_ram;
      else if (wb_adr[15:10] == 6'b101100)
         bus.region = atom_pkg::region_pia;
      else if (wb_adr[15:10] == 6'b101101)
         bus.region = atom_pkg::region_pl8;
      else
         // VIA, SPI and video space land here too
         bus.region = atom_pkg::region_open_bus;
   end

   assign bus.pia_reg = atom_pkg::pia_reg_e'(wb_adr[1:0]);
   assign bus.we      = wb_we;
   assign bus.adr     = wb_adr;
   assign bus.dat_w   = wb_dat_w;

   // One access per request, on the first enable while it is held
   assign bus.access = wb_cyc && wb_stb && cpu_clken && !ack_pending && !served;

   // Also covers a master that keeps stb up past the ack cycle
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         served <= 1'b0;
      else if (!wb_stb)
         served <= 1'b0;
      else if (bus.access)
         served <= 1'b1;
   end

endmodule

`default_nettype wire

//--- design/bus_response.sv
// ============================================================
// Bus response
// Read data multiplexor, Wishbone acknowledge and the
// external SRAM strobes
// ============================================================
`timescale 1ns/1ns
`default_nettype none

module bus_response
   (
   input  wire logic                          clk25,
   input  wire logic                          reset,
   atom_bus_if.sink                           bus,
   input  wire logic                          wb_stb,
   input  wire logic [atom_pkg::DATA_W-1:0]   pia_dout,
   input  wire logic [atom_pkg::DATA_W-1:0]   ram_dat_in,
   output logic                               wb_ack,
   output logic [atom_pkg::DATA_W-1:0]        wb_dat_r,
   output logic                               ram_cs_b,
   output logic                               ram_oe_b,
   output logic                               ram_we_b,
   output logic [atom_pkg::RAM_ADDR_W-1:0]    ram_adr,
   output logic [atom_pkg::DATA_W-1:0]        ram_dat_out
   );

   logic [atom_pkg::DATA_W-1:0] rd_mux;
   // RAM and ROM both live in the external SRAM
   logic                        mem_sel;

   assign mem_sel = (bus.region == atom_pkg::region_ram) ||
                    (bus.region == atom_pkg::region_rom);

   // ============================================================
   // Read data
   // ============================================================

   always_comb
   begin
      case (bus.region)
         atom_pkg::region_ram,
         atom_pkg::region_rom: rd_mux = ram_dat_in;
         atom_pkg::region_pia: rd_mux = pia_dout;
         // Empty slot
         atom_pkg::region_pl8: rd_mux = '0;
         default:              rd_mux = bus.adr[15:8] & atom_pkg::OPEN_BUS_MASK;
      endcase
   end

   // Data captured on the access edge, valid through the ack cycle
   always_ff @(posedge clk25)
   begin
      if (bus.access)
         wb_dat_r <= rd_mux;
   end

   // One-cycle acknowledge per access
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         wb_ack <= 1'b0;
      else
         wb_ack <= bus.access;
   end

   // ============================================================
   // SRAM strobes
   // ============================================================

   assign ram_cs_b    = !(wb_stb && mem_sel);
   assign ram_oe_b    = !(wb_stb && mem_sel);
   // ROM region is write protected
   assign ram_we_b    = !(wb_stb && bus.we && (bus.region == atom_pkg::region_ram));
   assign ram_adr     = {{(atom_pkg::RAM_ADDR_W - atom_pkg::ADDR_W){1'b0}}, bus.adr};
   assign ram_dat_out = bus.dat_w;

endmodule

`default_nettype wire

//--- design/cassette_tone.sv
// ============================================================
// Cassette tone and output gating
// Toggles the tone every 208 CPU enables and gates it onto
// the cassette output from the port C control bits
// ============================================================
`timescale 1ns/1ns
`default_nettype none

module cassette_tone
   (
   input  wire logic       clk25,
   input  wire logic       reset,
   input  wire logic       cpu_clken,
   input  wire logic [3:0] pia_pc_out,
   output logic            cas_tone,
   output logic            cas_out,
   output logic            sound
   );

   logic [atom_pkg::CAS_DIV_W-1:0] cas_div;

   // At 1 MHz this gives about 2.4 kHz, as on the real machine
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         cas_div  <= '0;
         cas_tone <= 1'b0;
      end
      else if (cpu_clken)
      begin
         if (cas_div == atom_pkg::CAS_DIV_W'(atom_pkg::CAS_DIV_COUNT - 1))
         begin
            cas_div  <= '0;
            cas_tone <= !cas_tone;
         end
         else
            cas_div <= cas_div + 1'b1;
      end
   end

   // Two NANDs and an inverter on the board, PC0 enables, PC1 passes the tone
   assign cas_out = !pia_pc_out[0] || (pia_pc_out[1] && !cas_tone);

   // Speaker driven straight from PC2
   assign sound = pia_pc_out[2];

endmodule

`default_nettype wire

//--- design/clock_enable_gen.sv
// ============================================================
// CPU clock enable generator
// Divides clk25 into a 25-cycle frame and picks 1, 2, 4 or
// 8 enables per frame from the turbo setting
// ============================================================
`timescale 1ns/1ns
`default_nettype none

module clock_enable_gen
   (
   input  wire logic             clk25,
   input  wire logic             reset,
   input  wire atom_pkg::speed_e turbo,
   output logic                  cpu_clken
   );

   // Frame counter, 0 to 24
   logic [atom_pkg::CLKDIV_W-1:0] clkdiv;
   // Current count is an enable slot for the selected speed
   logic                          slot_match;
   logic                          in_window;

   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         clkdiv <= '0;
      else if (clkdiv == atom_pkg::CLKDIV_W'(atom_pkg::CLKDIV_PERIOD - 1))
         clkdiv <= '0;
      else
         clkdiv <= clkdiv + 1'b1;
   end

   // Fast speeds bunch their enables in counts 0 to 15
   assign in_window = (clkdiv < atom_pkg::CLKDIV_W'(atom_pkg::CLKDIV_WINDOW));

   always_comb
   begin
      case (turbo)
         // Count 0 only
         atom_pkg::speed_1mhz: slot_match = (clkdiv == '0);
         // Counts 0 and 8
         atom_pkg::speed_2mhz: slot_match = (clkdiv[2:0] == 3'd0) && in_window;
         // Counts 0, 4, 8, 12
         atom_pkg::speed_4mhz: slot_match = (clkdiv[1:0] == 2'd0) && in_window;
         // Even counts below 16
         default:              slot_match = !clkdiv[0] && in_window;
      endcase
   end

   // Registered, so the enable trails its matching count by one cycle
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         cpu_clken <= 1'b0;
      else
         cpu_clken <= slot_match;
   end

endmodule

`default_nettype wire

//--- design/pia_8255.sv
// ============================================================
// 8255 PIA model
// Fixed port directions: A out, B in, C low nibble out and
// high nibble in, with port C bit set/reset
// ============================================================
`timescale 1ns/1ns
`default_nettype none

module pia_8255
   (
   input  wire logic                  clk25,
   input  wire logic                  reset,
   atom_bus_if.sink                   bus,
   input  wire logic                  shift_n,
   input  wire logic                  ctrl_n,
   input  wire logic [5:0]            keyout,
   input  wire logic                  fs_n,
   input  wire logic                  rept_n,
   input  wire logic                  cas_in,
   input  wire logic                  cas_tone,
   output logic [atom_pkg::DATA_W-1:0] pia_pa,
   output logic [3:0]                 pia_pc_out,
   output logic [atom_pkg::DATA_W-1:0] pia_dout
   );

   // Write strobe for this block
   logic pia_wr;

   assign pia_wr = bus.access && bus.we && (bus.region == atom_pkg::region_pia);

   // ============================================================
   // Output registers
   // ============================================================

   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         pia_pa     <= '0;
         pia_pc_out <= '0;
      end
      else if (pia_wr)
      begin
         case (bus.pia_reg)
            // Keyboard row in bits 3:0, video mode in 7:4
            atom_pkg::pia_port_a:
               pia_pa <= bus.dat_w;
            // Only the low nibble of port C is an output
            atom_pkg::pia_port_c:
               pia_pc_out <= bus.dat_w[3:0];
            // Bit 7 clear means bit set/reset, bits 2:1 pick the bit
            atom_pkg::pia_control:
               if (!bus.dat_w[7])
                  pia_pc_out[bus.dat_w[2:1]] <= bus.dat_w[0];
            // Port B is input only
            default:
               ;
         endcase
      end
   end

   // ============================================================
   // Read back
   // ============================================================

   always_comb
   begin
      case (bus.pia_reg)
         atom_pkg::pia_port_a:
            pia_dout = pia_pa;
         // Keyboard columns with the modifier keys on top
         atom_pkg::pia_port_b:
            pia_dout = {shift_n, ctrl_n, keyout};
         // Field sync, repeat, cassette in and tone over the outputs
         atom_pkg::pia_port_c:
            pia_dout = {fs_n, rept_n, cas_in, cas_tone, pia_pc_out};
         // Mode register is write only
         default:
            pia_dout = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- filelist.f
design/atom_pkg.sv
design/atom_bus_if.sv
design/clock_enable_gen.sv
design/bus_decode.sv
design/pia_8255.sv
design/cassette_tone.sv
design/bus_response.sv
design/atom_io_top.sv
tb/atom_io_properties.sv
tb/atom_io_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the Atom I/O testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module atom_io_tb \
   -f filelist.f \
   -Mdir obj_dir

output=$(./obj_dir/Vatom_io_tb 2>&1 || true)
echo "$output"

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
   exit 0
else
   exit 1
fi

//--- tb/atom_io_properties.sv
// ============================================================
// Atom I/O slice bus properties
// Handshake, ROM write masking and reset state checks
// ============================================================
`timescale 1ns/1ns
`default_nettype none

module atom_io_properties
   (
   input wire logic        clk25,
   input wire logic        reset,
   input wire logic        wb_cyc,
   input wire logic        wb_stb,
   input wire logic        wb_ack,
   input wire logic [15:0] wb_adr,
   input wire logic        ram_cs_b,
   input wire logic        ram_oe_b,
   input wire logic        ram_we_b,
   input wire logic [7:0]  pia_pa,
   input wire logic [3:0]  pia_pc_out,
   input wire logic        cas_tone
   );

   // Single-cycle acknowledge
   ack_single_cycle: assert property (@(posedge clk25) disable iff (reset)
      wb_ack |=> !wb_ack)
      else $error("wb_ack high for two cycles");

   // Acknowledge only for a request held on the cycle before
   ack_after_request: assert property (@(posedge clk25) disable iff (reset)
      wb_ack |-> $past(wb_cyc && wb_stb))
      else $error("wb_ack without a held request");

   // Top quarter is ROM, never written
   rom_write_masked: assert property (@(posedge clk25)
      (wb_adr[15:14] == 2'b11) |-> ram_we_b)
      else $error("ram_we_b low in the ROM region");

   // Outputs idle once reset has been seen for a full cycle
   reset_idle: assert property (@(posedge clk25)
      (reset && $past(reset)) |-> (!wb_ack && ram_cs_b && ram_oe_b && ram_we_b &&
                                   pia_pa == 8'h00 && pia_pc_out == 4'h0 && !cas_tone))
      else $error("outputs active during reset");

endmodule

bind atom_io_top atom_io_properties u_atom_io_properties (
   .clk25      (clk25),
   .reset      (reset),
   .wb_cyc     (wb_cyc),
   .wb_stb     (wb_stb),
   .wb_ack     (wb_ack),
   .wb_adr     (wb_adr),
   .ram_cs_b   (ram_cs_b),
   .ram_oe_b   (ram_oe_b),
   .ram_we_b   (ram_we_b),
   .pia_pa     (pia_pa),
   .pia_pc_out (pia_pc_out),
   .cas_tone   (cas_tone)
);

`default_nettype wire

//--- tb/atom_io_tb.sv
// ============================================================
// Atom I/O slice testbench
// Table-driven Wishbone accesses against the PIA, SRAM and
// open-bus regions, then a cassette tone wait
// ============================================================
`timescale 1ns/1ns
`default_nettype none

module atom_io_tb;

   localparam int  CLK_PERIOD      = 40;
   localparam int  RESET_CYCLES    = 10;
   localparam int  TABLE_LEN       = 44;
   localparam int  ACK_LIMIT       = 30;
   localparam int  ACK_WORST       = 26;
   localparam int  FRAME_CYCLES    = 25;
   localparam int  TONE_HALF       = 208;
   localparam int  WATCHDOG_CYCLES = RESET_CYCLES + TABLE_LEN * ACK_LIMIT
                                     + 4 * TONE_HALF * FRAME_CYCLES;
   localparam time TONE_WAIT       = time'(2 * TONE_HALF * FRAME_CYCLES * CLK_PERIOD);
   localparam logic [31:0] SEED    = 32'hdbf00ded;

   typedef logic [atom_pkg::DATA_W-1:0] byte_t;

   // One bus access with its expected read data and PIA state afterwards
   typedef struct packed {
      logic [1:0]  turbo;
      logic        we;
      logic [15:0] adr;
      byte_t       wdat;
      byte_t       rexp;
      byte_t       rmask;
      byte_t       pa;
      logic [3:0]  pc;
   } entry_t;

   logic        clk25 = 1'b0;
   logic        reset;
   logic [1:0]  turbo;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   logic [15:0] wb_adr;
   byte_t       wb_dat_w;
   byte_t       wb_dat_r;
   logic        wb_ack;
   logic        ram_cs_b;
   logic        ram_oe_b;
   logic        ram_we_b;
   logic [17:0] ram_adr;
   byte_t       ram_dat_in;
   byte_t       ram_dat_out;
   logic        shift_n;
   logic        ctrl_n;
   logic        rept_n;
   logic [5:0]  keyout;
   logic        fs_n;
   logic        cas_in;
   logic        cas_out;
   logic        sound;
   byte_t       pia_pa;

   // Stimulus table and the PIA state tracked while it is built
   entry_t      table_q [TABLE_LEN];
   int          n_entries;
   logic [1:0]  build_turbo;
   byte_t       cur_pa;
   logic [3:0]  cur_pc;
   logic        run_passed    = 1'b0;
   logic        fail_reported = 1'b0;

   // SRAM behind the bus, 64K used of the 18-bit space
   byte_t       sram [0:65535];

   always #(CLK_PERIOD / 2) clk25 = !clk25;

   atom_io_top dut0 (
      .clk25 (clk25), .reset (reset), .turbo (turbo),
      .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
      .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
      .ram_cs_b (ram_cs_b), .ram_oe_b (ram_oe_b), .ram_we_b (ram_we_b),
      .ram_adr (ram_adr), .ram_dat_in (ram_dat_in), .ram_dat_out (ram_dat_out),
      .shift_n (shift_n), .ctrl_n (ctrl_n), .rept_n (rept_n), .keyout (keyout),
      .fs_n (fs_n), .cas_in (cas_in), .cas_out (cas_out), .sound (sound),
      .pia_pa (pia_pa)
   );

   // Asynchronous read, write while the strobe is low
   assign ram_dat_in = sram[ram_adr[15:0]];

   always @(posedge clk25)
   begin
      if (!ram_we_b)
         sram[ram_adr[15:0]] = ram_dat_out;
   end

   // ============================================================
   // Reference rules
   // ============================================================

   // Power-up contents, both address bytes mixed in
   function automatic byte_t sram_fill(input logic [15:0] adr);
      return adr[15:8] ^ {adr[6:0], adr[7]};
   endfunction

   function automatic atom_pkg::region_e region_of(input logic [15:0] adr);
      if (adr[15:14] == 2'b11)
         return atom_pkg::region_rom;
      else if (!adr[15])
         return atom_pkg::region_ram;
      else if (adr >= 16'hB000 && adr <= 16'hB3FF)
         return atom_pkg::region_pia;
      else if (adr >= 16'hB400 && adr <= 16'hB7FF)
         return atom_pkg::region_pl8;
      else
         return atom_pkg::region_open_bus;
   endfunction

   function automatic byte_t open_bus_value(input logic [15:0] adr);
      return adr[15:8] & 8'hF1;
   endfunction

   // Tone bit left as zero, masked out on compare
   function automatic byte_t port_c_expect();
      return {fs_n, rept_n, cas_in, 1'b0, cur_pc};
   endfunction

   // PC0 low forces the output, PC1 passes the inverted tone
   function automatic logic cassette_rule(input logic [3:0] pc, input logic tone);
      return !pc[0] || (pc[1] && !tone);
   endfunction

   // ============================================================
   // Checks and bus master
   // ============================================================

   task automatic compare_value(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
      if (actual !== expected)
      begin
         fail_reported = 1'b1;
         $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
         $display("CHECKS FAILED");
         $fatal(1, "value mismatch on %s", name);
      end
   endtask

   // One Wishbone classic access, called and returning on a falling edge
   task automatic bus_access(input logic [1:0] t, input logic we, input logic [15:0] adr,
                             input byte_t wdat, output byte_t rdat, output logic cas_seen);
      int waited;
      int we_low;
      atom_pkg::region_e region;
      region   = region_of(adr);
      turbo    = t;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdat;
      waited   = 1;
      we_low   = 0;
      // cas_out from the cycle whose tone the read captures
      cas_seen = cas_out;
      @(negedge clk25);
      while (!wb_ack)
      begin
         if (waited >= ACK_LIMIT)
         begin
            fail_reported = 1'b1;
            $display("No acknowledge for the access to %h within %0d cycles", adr, ACK_LIMIT);
            $display("CHECKS FAILED");
            $fatal(1, "bus access timed out");
         end
         else
         begin
            cas_seen = cas_out;
            if (!ram_we_b)
               we_low++;
            waited++;
            @(negedge clk25);
         end
      end
      // Request still held on the ack cycle
      if (!ram_we_b)
         we_low++;
      compare_value($sformatf("ack latency ok @%h", adr), 32'(waited <= ACK_WORST), 32'd1);
      compare_value($sformatf("ram_we_b strobed @%h", adr), 32'(we_low != 0),
                    32'(we && region == atom_pkg::region_ram));
      if (region == atom_pkg::region_ram || region == atom_pkg::region_rom)
      begin
         compare_value("ram_cs_b", 32'(ram_cs_b), 32'd0);
         compare_value("ram_oe_b", 32'(ram_oe_b), 32'd0);
         compare_value("ram_adr", 32'(ram_adr), 32'({2'b00, adr}));
      end
      else
      begin
         // SRAM stays deselected outside RAM and ROM
         compare_value("ram_cs_b", 32'(ram_cs_b), 32'd1);
         compare_value("ram_oe_b", 32'(ram_oe_b), 32'd1);
      end
      if (we && region == atom_pkg::region_ram)
         compare_value("ram_dat_out", 32'(ram_dat_out), 32'(wdat));
      rdat   = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      // Idle cycle between accesses
      @(negedge clk25);
   endtask

   // ============================================================
   // Stimulus table
   // ============================================================

   task automatic add_entry(input logic we, input logic [15:0] adr, input byte_t wdat,
                            input byte_t rexp, input byte_t rmask);
      entry_t e;
      // PIA state as the 8255 rules leave it after this access
      if (we && region_of(adr) == atom_pkg::region_pia)
      begin
         case (adr[1:0])
            2'd0: cur_pa = wdat;
            2'd2: cur_pc = wdat[3:0];
            2'd3:
               if (!wdat[7])
                  cur_pc[wdat[2:1]] = wdat[0];
            default: ;
         endcase
      end
      e.turbo = build_turbo;
      e.we    = we;
      e.adr   = adr;
      e.wdat  = wdat;
      e.rexp  = rexp;
      e.rmask = rmask;
      e.pa    = cur_pa;
      e.pc    = cur_pc;
      table_q[n_entries] = e;
      n_entries++;
   endtask

   task automatic write_entry(input logic [15:0] adr, input byte_t wdat);
      add_entry(1'b1, adr, wdat, 8'h00, 8'h00);
   endtask

   task automatic read_entry(input logic [15:0] adr, input byte_t rexp, input byte_t rmask);
      add_entry(1'b0, adr, 8'h00, rexp, rmask);
   endtask

   task automatic build_table();
      byte_t rnd;
      n_entries   = 0;
      build_turbo = 2'd0;
      cur_pa      = 8'h00;
      cur_pc      = 4'h0;
      // Reset values
      read_entry(16'hB000, 8'h00, 8'hFF);
      read_entry(16'hB002, port_c_expect(), 8'hEF);
      // Port A read back
      rnd = 8'($urandom);
      write_entry(16'hB000, rnd);
      read_entry(16'hB000, rnd, 8'hFF);
      // Port C keeps the low nibble
      // PC3 up and the rest down so each set/reset below shows
      write_entry(16'hB002, {4'($urandom), 4'b1000});
      read_entry(16'hB002, port_c_expect(), 8'hEF);
      // Bit set/reset, PC2 up then down, then PC0 and PC1
      write_entry(16'hB003, 8'h05);
      read_entry(16'hB002, port_c_expect(), 8'hEF);
      write_entry(16'hB003, 8'h04);
      read_entry(16'hB002, port_c_expect(), 8'hEF);
      write_entry(16'hB003, 8'h01);
      write_entry(16'hB003, 8'h03);
      read_entry(16'hB002, port_c_expect(), 8'hEF);
      // Mode word with low bits that would raise PC2 as a set/reset
      write_entry(16'hB003, {1'b1, 4'($urandom), 3'b101});
      read_entry(16'hB002, port_c_expect(), 8'hEF);
      // Keyboard columns
      read_entry(16'hB001, {shift_n, ctrl_n, keyout}, 8'hFF);
      // RAM, ROM, empty slot and open bus
      rnd = 8'($urandom);
      write_entry(16'h1234, rnd);
      read_entry(16'h1234, rnd, 8'hFF);
      read_entry(16'h5A5A, sram_fill(16'h5A5A), 8'hFF);
      write_entry(16'hC123, 8'($urandom));
      read_entry(16'hC123, sram_fill(16'hC123), 8'hFF);
      read_entry(16'hB400, 8'h00, 8'hFF);
      read_entry(16'hB7FF, 8'h00, 8'hFF);
      read_entry(16'h9A55, open_bus_value(16'h9A55), 8'hFF);
      read_entry(16'hA3C7, open_bus_value(16'hA3C7), 8'hFF);
      read_entry(16'hB800, open_bus_value(16'hB800), 8'hFF);
      read_entry(16'hBFFF, open_bus_value(16'hBFFF), 8'hFF);
      // Every turbo setting
      for (int t = 0; t < 4; t++)
      begin
         build_turbo = 2'(t);
         rnd = 8'($urandom);
         write_entry(16'(16'h0040 + t), rnd);
         read_entry(16'(16'h0040 + t), rnd, 8'hFF);
         read_entry(16'hB000, cur_pa, 8'hFF);
      end
      // PC0 and PC1 high put the inverted tone on cas_out
      build_turbo = 2'd0;
      write_entry(16'hB002, 8'h03);
      read_entry(16'hB002, port_c_expect(), 8'hEF);
   endtask

   // ============================================================
   // Main sequence
   // ============================================================

   initial
   begin
      byte_t  rdat;
      logic   cas_seen;
      entry_t e;
      logic   tone_start;
      logic   tone_now;
      time    t_start;
      void'($urandom(SEED));
      reset    = 1'b1;
      turbo    = 2'd0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = 16'h0000;
      wb_dat_w = 8'h00;
      shift_n  = 1'b1;
      ctrl_n   = 1'b1;
      rept_n   = 1'b1;
      keyout   = 6'h3F;
      fs_n     = 1'b1;
      cas_in   = 1'b0;
      for (int i = 0; i < 65536; i++)
         sram[i] = sram_fill(16'(i));
      repeat (RESET_CYCLES) @(negedge clk25);
      reset = 1'b0;
      // Held keyboard and status levels
      {shift_n, ctrl_n, keyout} = 8'($urandom);
      {fs_n, rept_n, cas_in}    = 3'($urandom);
      @(negedge clk25);
      compare_value("pia_pa", 32'(pia_pa), 32'd0);
      build_table();
      for (int i = 0; i < n_entries; i++)
      begin
         e = table_q[i];
         bus_access(e.turbo, e.we, e.adr, e.wdat, rdat, cas_seen);
         if (!e.we)
            compare_value($sformatf("wb_dat_r @%h", e.adr), 32'(rdat & e.rmask),
                          32'(e.rexp & e.rmask));
         compare_value("pia_pa", 32'(pia_pa), 32'(e.pa));
         compare_value("sound", 32'(sound), 32'(e.pc[2]));
         if (!e.we && region_of(e.adr) == atom_pkg::region_pia && e.adr[1:0] == 2'd2)
            compare_value("cas_out", 32'(cas_seen), 32'(cassette_rule(e.pc, rdat[4])));
      end
      // Poll port C at 1 MHz until the tone flips
      bus_access(2'd0, 1'b0, 16'hB002, 8'h00, rdat, cas_seen);
      compare_value("cas_out", 32'(cas_seen), 32'(cassette_rule(cur_pc, rdat[4])));
      tone_start = rdat[4];
      tone_now   = tone_start;
      t_start    = $time;
      while (tone_now == tone_start && ($time - t_start) < TONE_WAIT)
      begin
         bus_access(2'd0, 1'b0, 16'hB002, 8'h00, rdat, cas_seen);
         compare_value("cas_out", 32'(cas_seen), 32'(cassette_rule(cur_pc, rdat[4])));
         tone_now = rdat[4];
      end
      compare_value("cassette tone changed", 32'(tone_now != tone_start), 32'd1);
      run_passed = 1'b1;
      $display("ALL CHECKS PASSED");
      $finish;
   end

   // Watchdog
   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk25);
      fail_reported = 1'b1;
      $display("Watchdog expired before the tests finished");
      $display("CHECKS FAILED");
      $fatal(1, "watchdog timeout");
   end

   // A run stopped by an assertion
   final
   begin
      if (!run_passed && !fail_reported)
         $display("CHECKS FAILED");
   end

endmodule

`default_nettype wire
